//--- flist.f
+incdir+bench
source/ex_pkg.sv
source/alu_int.sv
source/mul_unit.sv
source/div_unit.sv
source/hilo_reg.sv
source/ex_stage.sv
bench/tb_ex_stage.sv

//--- bench/tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

logic [31:0] lfsr_q = 32'd889;  // random source state
word_t       m_hi   = '0;       // model hi
word_t       m_lo   = '0;       // model lo

// ========================================================================
// random source
// ========================================================================
// one lfsr step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic        fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // x^32+x^22+x^2+x+1
		lfsr_q = {lfsr_q[30:0], fb};
		v      = {v[30:0], fb};
	end
	return v;
endfunction

// ========================================================================
// reference model
// ========================================================================
function automatic word_t lead_count(input word_t v, input logic bit_val);
	word_t n;
	n = '0;
	for (int i = XLEN - 1; i >= 0 && v[i] == bit_val; i--)
		n = n + 1'b1;                      // stops at first other bit
	return n;
endfunction

// expected result at issue time, hi/lo updated in issue order
function automatic ex_res_t model_exec(input ex_req_t r);
	ex_res_t e;
	dword_t  p;
	word_t   ma;
	word_t   mb;
	word_t   q;
	word_t   rm;
	logic    sg;
	e  = '{wd: r.wd, wreg: r.wreg, wdata: '0, ov: 1'b0};
	p  = dword_t'(longint'($signed(r.a)) * longint'($signed(r.b)));
	sg = (r.op == OP_DIV);
	ma = (sg && r.a[XLEN-1]) ? -r.a : r.a;   // magnitudes for div
	mb = (sg && r.b[XLEN-1]) ? -r.b : r.b;
	case (r.op)
		OP_OR:   e.wdata = r.a | r.b;
		OP_AND:  e.wdata = r.a & r.b;
		OP_NOR:  e.wdata = ~(r.a | r.b);
		OP_XOR:  e.wdata = r.a ^ r.b;
		OP_SLL:  e.wdata = r.b << r.a[4:0];
		OP_SRL:  e.wdata = r.b >> r.a[4:0];
		OP_SRA:  e.wdata = $signed(r.b) >>> r.a[4:0];
		OP_ADD, OP_ADDU: begin
			e.wdata = r.a + r.b;
			e.ov    = (r.op == OP_ADD) && (r.a[31] == r.b[31]) && (e.wdata[31] != r.a[31]);
		end
		OP_SUB, OP_SUBU: begin
			e.wdata = r.a - r.b;
			e.ov    = (r.op == OP_SUB) && (r.a[31] != r.b[31]) && (e.wdata[31] != r.a[31]);
		end
		OP_SLT:  e.wdata = word_t'($signed(r.a) < $signed(r.b));
		OP_SLTU: e.wdata = word_t'(r.a < r.b);
		OP_CLZ:  e.wdata = lead_count(r.a, 1'b0);
		OP_CLO:  e.wdata = lead_count(r.a, 1'b1);
		OP_MUL:  e.wdata = p[XLEN-1:0];
		OP_MULT: {m_hi, m_lo} = p;
		OP_MULTU: {m_hi, m_lo} = dword_t'(r.a) * dword_t'(r.b);
		OP_DIV, OP_DIVU: begin
			q  = (r.b == '0) ? '0 : ma / mb;  // zero divisor gives zeros
			rm = (r.b == '0) ? '0 : ma % mb;
			if (sg && (r.a[31] ^ r.b[31]))
				q = -q;
			if (sg && r.a[31])
				rm = -rm;                       // remainder follows dividend
			m_hi    = rm;
			m_lo    = q;
			e.wreg  = 1'b0;
			e.wdata = q;
		end
		OP_MFHI: e.wdata = m_hi;
		OP_MFLO: e.wdata = m_lo;
		OP_MTHI: m_hi = r.a;
		OP_MTLO: m_lo = r.a;
		default: e.wdata = '0;
	endcase
	e.wreg = e.wreg && !e.ov;                  // overflow drops the write
	return e;
endfunction

// ========================================================================
// compare tasks
// ========================================================================
// fields in order wd/wreg/wdata/ov
task automatic check_res(input string name, input ex_res_t got, input ex_res_t exp);
	if (got !== exp) begin
		$display("** Error at %0t: %s got %0d/%b/%h/%b exp %0d/%b/%h/%b", $time, name,
			got.wd, got.wreg, got.wdata, got.ov, exp.wd, exp.wreg, exp.wdata, exp.ov);
		fail_stop();
	end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("** Error at %0t: %s got %h exp %h", $time, name, got, exp);
		fail_stop();
	end
endtask

`endif

//--- bench/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
	import ex_pkg::*;

	localparam int N_OPS       = 400;   // total requests
	localparam int N_DIR       = 19;    // directed ones first
	localparam int REQ_TIMEOUT = 200;   // cycles for one acceptance
	localparam int RES_TIMEOUT = 200;   // cycles to drain results

	logic    clk;
	logic    reset_i;
	ex_req_t req_i;
	logic    req_valid_i;
	logic    req_ready_o;
	ex_res_t res_o;
	logic    res_valid_o;
	logic    res_ready_i;

	ex_res_t exp_q[$];                  // expected results in order
	int      n_acc      = 0;            // accepted requests
	int      n_res      = 0;            // results taken
	int      div_cnt    = 0;            // edges left with divider busy
	logic    held_valid = 1'b0;
	ex_res_t held_res;                  // result seen under back-pressure

	`include "tb_ex_model.svh"

	ex_stage dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.req_i       (req_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.res_o       (res_o),
		.res_valid_o (res_valid_o),
		.res_ready_i (res_ready_i)
	);

	task automatic fail_stop();
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	// ========================================================================
	// stimulus sources
	// ========================================================================
	// destination follows the index
	function automatic ex_req_t make_req(input alu_op_e op, input word_t a, input word_t b,
		input int i);
		ex_req_t r;
		r = '{op: op, a: a, b: b, wd: reg_addr_t'(i), wreg: 1'b1};
		return r;
	endfunction

	function automatic ex_req_t directed_req(input int i);
		ex_req_t r;
		case (i)
			1:  r = make_req(OP_ADD,  32'h7fff_ffff, 32'h1,         i); // overflow
			2:  r = make_req(OP_SUB,  32'h8000_0000, 32'h1,         i); // overflow
			3:  r = make_req(OP_ADDU, 32'h7fff_ffff, 32'h1,         i);
			4:  r = make_req(OP_SLT,  32'hffff_fffe, 32'h1,         i);
			5:  r = make_req(OP_SLTU, 32'hffff_fffe, 32'h1,         i);
			6:  r = make_req(OP_SRA,  32'h4,         32'h8000_00f0, i);
			7:  r = make_req(OP_CLO,  32'hffff_ff00, 32'h0,         i);
			8:  r = make_req(OP_MULT, 32'hffff_fffd, 32'h7,         i);
			10: r = make_req(OP_MFLO, 32'h0,         32'h0,         i);
			11: r = make_req(OP_MUL,  32'hffff_fffd, 32'h7,         i);
			12: r = make_req(OP_MTHI, 32'h1234_5678, 32'h0,         i);
			13: r = make_req(OP_MFLO, 32'h0,         32'h0,         i); // lo untouched
			14: r = make_req(OP_DIV,  32'hffff_ff9c, 32'h7,         i);
			16: r = make_req(OP_MFLO, 32'h0,         32'h0,         i);
			17: r = make_req(OP_DIVU, 32'hffff_ff9c, 32'h0,         i); // zero divisor
			default: r = make_req(OP_MFHI, 32'h0, 32'h0, i);             // 0, 9, 15, 18
		endcase
		return r;
	endfunction

	function automatic ex_req_t random_req();
		ex_req_t r;
		r.op   = alu_op_e'(rand_bits(5) % 25);
		r.a    = rand_bits(32);
		r.b    = rand_bits(32);
		r.wd   = reg_addr_t'(rand_bits(5));
		r.wreg = (rand_bits(1) != 0);
		case (rand_bits(3))
			3'd0: r.b = '0;                  // zero divisor
			3'd1: r.a = '0;                  // clz full count
			3'd2: r.a = '1;                  // clo full count
			3'd3: r.b = r.b >> rand_bits(5); // small divisor
			default: r.b = r.b;
		endcase
		return r;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================================================
	// monitor, sampled at the rising edge
	// ========================================================================
	always @(posedge clk) begin
		ex_res_t exp_r;
		if (!reset_i) begin
			if (div_cnt > 0) begin
				if (req_ready_o) begin
					$display("req_ready_o went high at %0t while the divider ran", $time);
					fail_stop();
				end
				div_cnt = div_cnt - 1;
			end
			if (res_valid_o && held_valid)
				check_res("res_o held", res_o, held_res);
			if (res_valid_o && res_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("result at %0t with no request outstanding", $time);
					fail_stop();
				end
				exp_r = exp_q.pop_front();
				check_word("res_o.wdata", res_o.wdata, exp_r.wdata);
				check_res("res_o", res_o, exp_r);
				n_res = n_res + 1;
			end
			held_valid = res_valid_o && !res_ready_i;
			held_res   = res_o;
			if (req_valid_i && req_ready_o) begin
				exp_q.push_back(model_exec(req_i));
				n_acc = n_acc + 1;
				if (req_i.op == OP_DIV || req_i.op == OP_DIVU)
					div_cnt = 33;                // busy through the done edge
			end
		end
	end

	// ========================================================================
	// driver, falling edge
	// ========================================================================
	initial begin
		int issued;
		int acc_seen;
		int wait_cnt;
		$timeformat(-9, 0, " ns", 0);
		issued      = 0;
		acc_seen    = 0;
		wait_cnt    = 0;
		reset_i     = 1'b1;
		req_i       = '0;
		req_valid_i = 1'b0;
		res_ready_i = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);
		if (res_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
			$display("after reset res_valid_o=%b req_ready_o=%b, want 0 and 1",
				res_valid_o, req_ready_o);
			fail_stop();
		end
		while (n_acc < N_OPS) begin
			@(negedge clk);
			res_ready_i = (rand_bits(2) != 2'b00);  // stall one cycle in four
			if (n_acc != acc_seen) begin
				acc_seen    = n_acc;
				req_valid_i = 1'b0;
				wait_cnt    = 0;
			end else if (req_valid_i) begin
				wait_cnt = wait_cnt + 1;
			end
			if (wait_cnt > REQ_TIMEOUT) begin
				$display("request %0d not accepted within %0d cycles", issued, REQ_TIMEOUT);
				fail_stop();
			end
			if (!req_valid_i && issued < N_OPS && (issued < N_DIR || rand_bits(1))) begin
				req_i       = (issued < N_DIR) ? directed_req(issued) : random_req();
				req_valid_i = 1'b1;
				issued      = issued + 1;
			end
		end
		wait_cnt = 0;
		while (exp_q.size() != 0 && wait_cnt <= RES_TIMEOUT) begin
			@(negedge clk);
			res_ready_i = 1'b1;
			wait_cnt    = wait_cnt + 1;
		end
		if (exp_q.size() != 0 || n_res != N_OPS) begin
			$display("only %0d of %0d results arrived before the timeout", n_res, N_OPS);
			fail_stop();
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- source/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic            clk,
	input  logic            reset_i,
	input  ex_pkg::ex_req_t req_i,
	input  logic            req_valid_i,
	output logic            req_ready_o,
	output ex_pkg::ex_res_t res_o,
	output logic            res_valid_o,
	input  logic            res_ready_i
);
	import ex_pkg::*;

	word_t     alu_res;
	logic      alu_ov;
	dword_t    product;
	logic      mul_signed;
	logic      div_start;
	logic      div_signed;
	logic      div_busy;
	logic      div_done;
	logic      div_ack;     // result taken from divider
	word_t     div_quot;
	word_t     div_rem;
	word_t     hi;
	word_t     lo;
	hilo_wr_t  hilo_wr;
	logic      accept;      // request handshake this edge
	logic      is_div;
	logic      res_free;    // result reg can load
	logic      res_load;
	word_t     gpr_data;
	ex_res_t   res_d;
	ex_res_t   res_q;
	logic      res_valid_q;
	reg_addr_t div_wd_q;    // destination of pending division

	// ========================================================================
	// handshake and decode
	// ========================================================================
	assign res_free    = !res_valid_q || res_ready_i;
	assign req_ready_o = !div_busy && res_free;
	assign accept      = req_valid_i && req_ready_o;

	assign is_div     = (req_i.op == OP_DIV) || (req_i.op == OP_DIVU);
	assign div_start  = accept && is_div;
	assign div_signed = (req_i.op == OP_DIV);
	assign mul_signed = (req_i.op == OP_MUL) || (req_i.op == OP_MULT);
	assign div_ack    = div_done && res_free;           // wait while result held
	assign res_load   = (accept && !is_div) || div_ack;

	alu_int u_alu (
		.op_i     (req_i.op),
		.a_i      (req_i.a),
		.b_i      (req_i.b),
		.result_o (alu_res),
		.ov_o     (alu_ov)
	);

	mul_unit u_mul (
		.signed_i  (mul_signed),
		.a_i       (req_i.a),
		.b_i       (req_i.b),
		.product_o (product)
	);

	div_unit #(
		.WIDTH (XLEN)
	) u_div (
		.clk        (clk),
		.reset_i    (reset_i),
		.start_i    (div_start),
		.signed_i   (div_signed),
		.dividend_i (req_i.a),
		.divisor_i  (req_i.b),
		.ack_i      (div_ack),
		.busy_o     (div_busy),
		.done_o     (div_done),
		.quot_o     (div_quot),
		.rem_o      (div_rem)
	);

	hilo_reg u_hilo (
		.clk     (clk),
		.reset_i (reset_i),
		.wr_i    (hilo_wr),
		.hi_o    (hi),
		.lo_o    (lo)
	);

	// ========================================================================
	// hi/lo write select
	// ========================================================================
	always_comb begin
		hilo_wr = '0;
		if (div_ack) begin                    // same edge as result load
			hilo_wr.we_hi = 1'b1;
			hilo_wr.we_lo = 1'b1;
			hilo_wr.hi    = div_rem;
			hilo_wr.lo    = div_quot;
		end else if (accept) begin
			case (req_i.op)
				OP_MULT, OP_MULTU: begin
					hilo_wr.we_hi = 1'b1;
					hilo_wr.we_lo = 1'b1;
					hilo_wr.hi    = product[2*XLEN-1:XLEN];
					hilo_wr.lo    = product[XLEN-1:0];
				end
				OP_MTHI: begin
					hilo_wr.we_hi = 1'b1;
					hilo_wr.hi    = req_i.a;
				end
				OP_MTLO: begin
					hilo_wr.we_lo = 1'b1;
					hilo_wr.lo    = req_i.a;
				end
				default: hilo_wr = '0;
			endcase
		end
	end

	// ========================================================================
	// result mux and register
	// ========================================================================
	always_comb begin
		case (req_i.op)
			OP_MUL:  gpr_data = product[XLEN-1:0]; // low word only
			OP_MFHI: gpr_data = hi;
			OP_MFLO: gpr_data = lo;
			default: gpr_data = alu_res;           // zero for hi/lo writers
		endcase
	end

	always_comb begin
		if (div_ack) begin
			res_d.wd    = div_wd_q;
			res_d.wreg  = 1'b0;                 // division only updates hi/lo
			res_d.wdata = div_quot;
			res_d.ov    = 1'b0;
		end else begin
			res_d.wd    = req_i.wd;
			res_d.wreg  = req_i.wreg && !alu_ov; // overflow kills write
			res_d.wdata = gpr_data;
			res_d.ov    = alu_ov;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			res_valid_q <= 1'b0;
		else if (res_load)
			res_valid_q <= 1'b1;
		else if (res_ready_i)
			res_valid_q <= 1'b0;                // drained
	end

	always_ff @(posedge clk) begin
		if (res_load)
			res_q <= res_d;                     // only when free, so held stable
		if (div_start)
			div_wd_q <= req_i.wd;
	end

	assign res_o       = res_q;
	assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

//--- source/hilo_reg.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_reg (
	input  logic             clk,
	input  logic             reset_i,
	input  ex_pkg::hilo_wr_t wr_i,
	output ex_pkg::word_t    hi_o,
	output ex_pkg::word_t    lo_o
);
	import ex_pkg::*;

	word_t hi_q;
	word_t lo_q;

	// ========================================================================
	// independent enables
	// ========================================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			if (wr_i.we_hi)
				hi_q <= wr_i.hi;  // mthi leaves lo alone
			if (wr_i.we_lo)
				lo_q <= wr_i.lo;  // mtlo leaves hi alone
		end
	end

	assign hi_o = hi_q;
	assign lo_o = lo_q;

endmodule

`default_nettype wire

//--- source/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             start_i,
	input  logic             signed_i,
	input  logic [WIDTH-1:0] dividend_i,
	input  logic [WIDTH-1:0] divisor_i,
	input  logic             ack_i,
	output logic             busy_o,
	output logic             done_o,
	output logic [WIDTH-1:0] quot_o,
	output logic [WIDTH-1:0] rem_o
);

	localparam int CNT_W = $clog2(WIDTH);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

	state_e           state_q;
	logic [CNT_W-1:0] step_q;      // current bit step
	logic [WIDTH-1:0] rem_q;       // partial remainder
	logic [WIDTH-1:0] quot_q;      // dividend shifts out, quotient in
	logic [WIDTH-1:0] dvs_q;       // divisor magnitude
	logic             neg_quot_q;  // signs differed
	logic             neg_rem_q;   // dividend was negative
	logic             zero_q;      // divide by zero
	logic [WIDTH-1:0] mag_dvd;
	logic [WIDTH-1:0] mag_dvs;
	logic [WIDTH:0]   trial;       // remainder with next dividend bit
	logic [WIDTH:0]   diff;        // msb set means borrow

	assign mag_dvd = (signed_i && dividend_i[WIDTH-1]) ? (~dividend_i + 1'b1) : dividend_i;
	assign mag_dvs = (signed_i && divisor_i[WIDTH-1]) ? (~divisor_i + 1'b1) : divisor_i;

	assign trial = {rem_q, quot_q[WIDTH-1]};
	assign diff  = trial - {1'b0, dvs_q};

	// ========================================================================
	// control
	// ========================================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= S_IDLE;
			step_q  <= '0;
		end else begin
			case (state_q)
				S_IDLE: if (start_i) begin
					state_q <= S_RUN;
					step_q  <= '0;
				end
				S_RUN: begin
					step_q <= step_q + 1'b1;
					if (step_q == CNT_W'(WIDTH - 1))
						state_q <= S_DONE;  // last step this edge
				end
				S_DONE: if (ack_i)
					state_q <= S_IDLE;     // held until result taken
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// ========================================================================
	// restoring datapath
	// ========================================================================
	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && start_i) begin
			rem_q      <= '0;
			quot_q     <= mag_dvd;
			dvs_q      <= mag_dvs;
			neg_quot_q <= signed_i && (dividend_i[WIDTH-1] ^ divisor_i[WIDTH-1]);
			neg_rem_q  <= signed_i && dividend_i[WIDTH-1];
			zero_q     <= (divisor_i == '0);
		end else if (state_q == S_RUN) begin
			if (!diff[WIDTH]) begin                 // fits, keep difference
				rem_q  <= diff[WIDTH-1:0];
				quot_q <= {quot_q[WIDTH-2:0], 1'b1};
			end else begin                          // restore
				rem_q  <= trial[WIDTH-1:0];
				quot_q <= {quot_q[WIDTH-2:0], 1'b0};
			end
		end
	end

	assign busy_o = (state_q != S_IDLE);   // covers the wait in done
	assign done_o = (state_q == S_DONE);

	// sign correction, zero divisor forces zeros
	assign quot_o = zero_q ? '0 : (neg_quot_q ? (~quot_q + 1'b1) : quot_q);
	assign rem_o  = zero_q ? '0 : (neg_rem_q ? (~rem_q + 1'b1) : rem_q);

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  logic           signed_i,
	input  ex_pkg::word_t  a_i,
	input  ex_pkg::word_t  b_i,
	output ex_pkg::dword_t product_o
);
	import ex_pkg::*;

	word_t  mag_a;    // |a| when signed
	word_t  mag_b;    // |b| when signed
	dword_t prod_u;   // unsigned magnitude product
	logic   neg;      // result sign

	assign mag_a = (signed_i && a_i[XLEN-1]) ? (~a_i + 1'b1) : a_i;
	assign mag_b = (signed_i && b_i[XLEN-1]) ? (~b_i + 1'b1) : b_i;

	assign prod_u = dword_t'(mag_a) * dword_t'(mag_b);

	// opposite signs give a negative product
	assign neg = signed_i && (a_i[XLEN-1] ^ b_i[XLEN-1]);

	assign product_o = neg ? (~prod_u + 1'b1) : prod_u;

endmodule

`default_nettype wire

//--- source/alu_int.sv
`timescale 1ns/1ps
`default_nettype none

module alu_int (
	input  ex_pkg::alu_op_e op_i,
	input  ex_pkg::word_t   a_i,
	input  ex_pkg::word_t   b_i,
	output ex_pkg::word_t   result_o,
	output logic            ov_o
);
	import ex_pkg::*;

	localparam int SHW  = $clog2(XLEN);     // shift amount bits
	localparam int CNTW = $clog2(XLEN) + 1; // count reaches XLEN

	logic            sub_op;  // adder in subtract mode
	word_t           b_mux;   // b or ~b into the adder
	word_t           sum;     // a + b or a - b
	logic            slt_s;   // signed a < b
	logic            slt_u;   // unsigned a < b
	logic [SHW-1:0]  shamt;
	logic [CNTW-1:0] lz_cnt;  // leading zeros of a
	logic [CNTW-1:0] lo_cnt;  // leading ones of a

	// scan from msb, stop at the first set bit
	function automatic logic [CNTW-1:0] lead_zeros(input word_t v);
		logic [CNTW-1:0] n;
		logic            hit;
		n   = '0;
		hit = 1'b0;
		for (int i = XLEN - 1; i >= 0; i--) begin
			if (v[i])
				hit = 1'b1;
			else if (!hit)
				n = n + 1'b1;
		end
		return n;
	endfunction

	// ========================================================================
	// shared adder
	// ========================================================================
	assign sub_op = op_i inside {OP_SUB, OP_SUBU, OP_SLT};
	assign b_mux  = sub_op ? ~b_i : b_i;               // invert, carry in below
	assign sum    = a_i + b_mux + word_t'(sub_op);     // two's complement

	// neg vs pos, or same signs and negative difference
	assign slt_s = (a_i[XLEN-1] && !b_i[XLEN-1]) ||
		((a_i[XLEN-1] == b_i[XLEN-1]) && sum[XLEN-1]);
	assign slt_u = a_i < b_i;

	// operands agree in sign but sum flips
	assign ov_o = (op_i inside {OP_ADD, OP_SUB}) &&
		(a_i[XLEN-1] == b_mux[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);

	assign shamt  = a_i[SHW-1:0];          // low bits of a only
	assign lz_cnt = lead_zeros(a_i);
	assign lo_cnt = lead_zeros(~a_i);      // ones become zeros

	// ========================================================================
	// result select
	// ========================================================================
	always_comb begin
		case (op_i)
			OP_OR:   result_o = a_i | b_i;
			OP_AND:  result_o = a_i & b_i;
			OP_NOR:  result_o = ~(a_i | b_i);
			OP_XOR:  result_o = a_i ^ b_i;
			OP_SLL:  result_o = b_i << shamt;
			OP_SRL:  result_o = b_i >> shamt;
			OP_SRA:  result_o = $signed(b_i) >>> shamt; // sign fill
			OP_ADD, OP_ADDU,
			OP_SUB, OP_SUBU:
				result_o = sum;
			OP_SLT:  result_o = word_t'(slt_s);
			OP_SLTU: result_o = word_t'(slt_u);
			OP_CLZ:  result_o = word_t'(lz_cnt);
			OP_CLO:  result_o = word_t'(lo_cnt);
			default: result_o = '0;                   // mul/div/move handled above
		endcase
	end

endmodule

`default_nettype wire

//--- source/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int XLEN       = 32;         // data word
	localparam int REG_ADDR_W = 5;          // gpr index

	typedef logic [XLEN-1:0]       word_t;     // one data word
	typedef logic [2*XLEN-1:0]     dword_t;    // product or {hi, lo}
	typedef logic [REG_ADDR_W-1:0] reg_addr_t; // destination gpr

	// ========================================================================
	// opcodes
	// ========================================================================
	typedef enum logic [5:0] {
		OP_NOP,   OP_OR,   OP_AND,   OP_NOR,  OP_XOR,  // logic
		OP_SLL,   OP_SRL,  OP_SRA,                     // shifts
		OP_ADD,   OP_ADDU, OP_SUB,   OP_SUBU,          // adder
		OP_SLT,   OP_SLTU, OP_CLZ,   OP_CLO,           // compare, count
		OP_MUL,   OP_MULT, OP_MULTU,                   // multiplier
		OP_DIV,   OP_DIVU,                             // iterative divider
		OP_MFHI,  OP_MFLO, OP_MTHI,  OP_MTLO           // hi/lo moves
	} alu_op_e;

	// ========================================================================
	// transfer structs
	// ========================================================================
	typedef struct packed {
		alu_op_e   op;    // operation
		word_t     a;     // rs, also shift amount
		word_t     b;     // rt or resolved immediate
		reg_addr_t wd;    // destination
		logic      wreg;  // gpr write wanted
	} ex_req_t;

	typedef struct packed {
		reg_addr_t wd;    // destination
		logic      wreg;  // gpr write, dropped on overflow
		word_t     wdata; // write data
		logic      ov;    // signed overflow seen
	} ex_res_t;

	typedef struct packed {
		logic  we_hi;     // hi enable
		logic  we_lo;     // lo enable
		word_t hi;
		word_t lo;
	} hilo_wr_t;

endpackage

`default_nettype wire
